// File: sim.f
source/na_pkg.sv
source/noc_flit_buffer.sv
source/ahb_slave_decode.sv
source/na_config_regs.sv
source/mp_endpoint.sv
source/network_adapter.sv
verif/tb_network_adapter.sv

// File: Makefile
VERILATOR  ?= verilator
FILELIST   ?= sim.f
TOP        ?= tb_network_adapter
RTL_TOP    ?= network_adapter
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --binary --timing -Wno-fatal
PASS_MSG   ?= TEST OK

RTL_SRCS := $(shell grep '^source/' $(FILELIST))
ALL_SRCS := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(ALL_SRCS)
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# Status comes from the search for the pass line
sim: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: verif/tb_network_adapter.sv
// Directed testbench that runs as top level over the network adapter sources of sim.f
`timescale 1ns/100ps

module tb_network_adapter;

  import na_pkg::*;

  localparam int          CLK_PERIOD     = 40;
  localparam int          DRIVE_DELAY    = 2;
  localparam int          TIMEOUT_CYCLES = 100;
  localparam logic [31:0] LFSR_SEED      = 32'd28;
  localparam logic [31:0] LFSR_TAPS      = 32'h8020_0003;

  // Register contents and address map as seen from the bus
  localparam xlen_t  EXP_TILE_ID    = 32'd5;
  localparam xlen_t  EXP_VERSION    = 32'd1;
  localparam laddr_t ADDR_ID        = 24'h000000;
  localparam laddr_t ADDR_VERSION   = 24'h000004;
  localparam laddr_t ADDR_SCRATCH   = 24'h000008;
  localparam laddr_t ADDR_MP_DATA   = 24'h100000;
  localparam laddr_t ADDR_MP_LAST   = 24'h100004;
  localparam laddr_t ADDR_MP_STATUS = 24'h100008;
  localparam laddr_t ADDR_UNMAPPED  = 24'h300000;

  logic        clk;
  logic        rst_n;
  ahb_req_t    ahb_req;
  ahb_rsp_t    ahb_rsp;
  noc_flit_t   noc_in;
  logic        noc_in_ready;
  noc_flit_t   noc_out;
  logic        noc_out_ready;
  logic        irq;
  logic [31:0] lfsr_q;
  noc_flit_t   out_seen_q[$];
  int          writes_done;

  network_adapter i_dut (
    .clk            (clk),
    .rst_n_i        (rst_n),
    .ahb_req_i      (ahb_req),
    .ahb_rsp_o      (ahb_rsp),
    .noc_in_i       (noc_in),
    .noc_in_ready_o (noc_in_ready),
    .noc_out_o      (noc_out),
    .noc_out_ready_i(noc_out_ready),
    .irq_o          (irq)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Records each flit that leaves on the coming rising edge
  initial begin
    forever begin
      @(posedge clk);
      #(DRIVE_DELAY + 1);
      if (rst_n && noc_out.valid && noc_out_ready) begin
        out_seen_q.push_back(noc_out);
      end
    end
  end

  ////////////////////
  // Helpers

  task automatic next_cycle();
    @(posedge clk);
    #(DRIVE_DELAY);
  endtask

  task automatic check_value(input string what, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, actual, expected);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("Timeout: waited %0d cycles for %s", TIMEOUT_CYCLES, what);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    logic [31:0] nxt;
    nxt = state >> 1;
    if (state[0]) begin
      nxt = nxt ^ LFSR_TAPS;
    end
    return nxt;
  endfunction

  // One LFSR step per payload bit
  task automatic random_word(output xlen_t word);
    word = '0;
    for (int i = 0; i < XLEN; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      word   = {word[XLEN-2:0], lfsr_q[0]};
    end
  endtask

  // Returns in the middle of the cycle whose closing edge has hready high
  task automatic wait_hready(input string what);
    int   waited;
    logic ready;
    waited = 0;
    #1;
    ready = ahb_rsp.hready;
    while (!ready && waited < TIMEOUT_CYCLES) begin
      next_cycle();
      #1;
      ready = ahb_rsp.hready;
      waited++;
    end
    if (!ready) begin
      stop_on_timeout(what);
    end
  endtask

  ////////////////////
  // Bus and NoC drivers

  task automatic ahb_write(input laddr_t addr, input xlen_t data);
    ahb_req.hsel   = 1'b1;
    ahb_req.haddr  = addr;
    ahb_req.hwrite = 1'b1;
    ahb_req.hsize  = 3'b010;
    ahb_req.htrans = HTRANS_NONSEQ;
    wait_hready("hready in a write address phase");
    next_cycle();
    ahb_req.hsel   = 1'b0;
    ahb_req.htrans = HTRANS_IDLE;
    ahb_req.hwdata = data;
    wait_hready("hready in a write data phase");
    next_cycle();
  endtask

  task automatic ahb_read(input laddr_t addr, output xlen_t data, output logic resp);
    ahb_req.hsel   = 1'b1;
    ahb_req.haddr  = addr;
    ahb_req.hwrite = 1'b0;
    ahb_req.hsize  = 3'b010;
    ahb_req.htrans = HTRANS_NONSEQ;
    wait_hready("hready in a read address phase");
    next_cycle();
    ahb_req.hsel   = 1'b0;
    ahb_req.htrans = HTRANS_IDLE;
    wait_hready("hready in a read data phase");
    data = ahb_rsp.hrdata;
    resp = ahb_rsp.hresp;
    next_cycle();
  endtask

  task automatic read_expect(input laddr_t addr, input xlen_t expected, input string what);
    xlen_t data;
    logic  resp;
    ahb_read(addr, data, resp);
    check_value({what, " hresp"}, resp, 1'b0);
    check_value(what, data, expected);
  endtask

  task automatic noc_send_flit(input flit_data_t data, input logic last);
    int   waited;
    logic ready;
    noc_in = '{valid: 1'b1, last: last, data: data};
    waited = 0;
    #1;
    ready = noc_in_ready;
    while (!ready && waited < TIMEOUT_CYCLES) begin
      next_cycle();
      #1;
      ready = noc_in_ready;
      waited++;
    end
    if (!ready) begin
      stop_on_timeout("noc_in_ready_o");
    end
    next_cycle();
    noc_in.valid = 1'b0;
  endtask

  task automatic noc_expect_flit(input flit_data_t data, input logic last);
    int        waited;
    noc_flit_t flit;
    waited = 0;
    while (out_seen_q.size() == 0 && waited < TIMEOUT_CYCLES) begin
      next_cycle();
      waited++;
    end
    if (out_seen_q.size() == 0) begin
      stop_on_timeout("a flit on noc_out_o");
    end
    flit = out_seen_q.pop_front();
    check_value("noc_out_o data", flit.data, data);
    check_value("noc_out_o last", flit.last, last);
  endtask

  ////////////////////
  // Directed tests

  task automatic check_after_reset();
    #1;
    check_value("noc_out_o valid after reset", noc_out.valid, 1'b0);
    check_value("hready after reset", ahb_rsp.hready, 1'b1);
    check_value("hresp after reset", ahb_rsp.hresp, 1'b0);
    check_value("irq_o after reset", irq, 1'b0);
    check_value("noc_in_ready_o after reset", noc_in_ready, 1'b1);
    next_cycle();
  endtask

  task automatic run_config_access();
    xlen_t value;
    read_expect(ADDR_ID, EXP_TILE_ID, "tile id");
    read_expect(ADDR_VERSION, EXP_VERSION, "version");
    read_expect(ADDR_SCRATCH, '0, "scratch after reset");
    random_word(value);
    ahb_write(ADDR_SCRATCH, value);
    read_expect(ADDR_SCRATCH, value, "scratch readback");
  endtask

  task automatic send_packet();
    xlen_t words [3];
    noc_out_ready = 1'b1;
    for (int i = 0; i < 3; i++) begin
      random_word(words[i]);
    end
    for (int i = 0; i < 3; i++) begin
      ahb_write((i == 2) ? ADDR_MP_LAST : ADDR_MP_DATA, words[i]);
    end
    for (int i = 0; i < 3; i++) begin
      noc_expect_flit(words[i], (i == 2));
    end
    repeat (4) next_cycle();
    check_value("extra flits after the packet", out_seen_q.size(), 0);
    check_value("noc_out_o valid when drained", noc_out.valid, 1'b0);
  endtask

  // Two packets of three words against a four-deep out buffer
  task automatic stall_on_full_buffer();
    xlen_t words [6];
    int    waited;
    logic  ready;
    noc_out_ready = 1'b0;
    writes_done   = 0;
    for (int i = 0; i < 6; i++) begin
      random_word(words[i]);
    end
    fork
      begin
        for (int i = 0; i < 6; i++) begin
          ahb_write(((i % 3) == 2) ? ADDR_MP_LAST : ADDR_MP_DATA, words[i]);
          writes_done++;
        end
      end
      begin
        waited = 0;
        #1;
        ready = ahb_rsp.hready;
        while (ready && waited < TIMEOUT_CYCLES) begin
          next_cycle();
          #1;
          ready = ahb_rsp.hready;
          waited++;
        end
        if (ready) begin
          stop_on_timeout("a write stall on the full out buffer");
        end
        check_value("writes done at the stall", writes_done, 4);
        repeat (6) begin
          next_cycle();
          #1;
          check_value("hready with the out buffer full", ahb_rsp.hready, 1'b0);
        end
        check_value("noc_out_o valid while full", noc_out.valid, 1'b1);
        check_value("head flit data while full", noc_out.data, words[0]);
        check_value("head flit last while full", noc_out.last, 1'b0);
        next_cycle();
        noc_out_ready = 1'b1;
      end
    join
    for (int i = 0; i < 6; i++) begin
      noc_expect_flit(words[i], ((i % 3) == 2));
    end
  endtask

  task automatic receive_packet();
    flit_data_t words [3];
    for (int i = 0; i < 3; i++) begin
      random_word(words[i]);
    end
    for (int i = 0; i < 3; i++) begin
      noc_send_flit(words[i], (i == 2));
    end
    #1;
    check_value("irq_o with flits waiting", irq, 1'b1);
    next_cycle();
    for (int i = 0; i < 3; i++) begin
      read_expect(ADDR_MP_STATUS, xlen_t'({(i == 2), 1'b1}), "endpoint status");
      read_expect(ADDR_MP_DATA, words[i], "received flit");
    end
    #1;
    check_value("irq_o after the last pop", irq, 1'b0);
    next_cycle();
    read_expect(ADDR_MP_DATA, '0, "data read with nothing waiting");
  endtask

  task automatic access_unmapped();
    xlen_t data;
    logic  resp;
    ahb_read(ADDR_UNMAPPED, data, resp);
    check_value("hresp on an unmapped read", resp, 1'b1);
    read_expect(ADDR_ID, EXP_TILE_ID, "tile id after an error");
  endtask

  ////////////////////
  // Sequence

  initial begin
    rst_n         = 1'b0;
    ahb_req       = '0;
    noc_in        = '0;
    noc_out_ready = 1'b0;
    lfsr_q        = LFSR_SEED;
    writes_done   = 0;
    repeat (4) @(posedge clk);
    #(DRIVE_DELAY);
    rst_n = 1'b1;

    check_after_reset();
    run_config_access();
    send_packet();
    stall_on_full_buffer();
    receive_packet();
    access_unmapped();

    $display("TEST OK");
    $finish;
  end

endmodule

// File: source/network_adapter.sv
// Top level of the message-passing network adapter between the AHB-Lite slave port and one NoC link
`timescale 1ns/100ps

module network_adapter (
  input  logic              clk,
  input  logic              rst_n_i,

  input  na_pkg::ahb_req_t  ahb_req_i,
  output na_pkg::ahb_rsp_t  ahb_rsp_o,

  input  na_pkg::noc_flit_t noc_in_i,
  output logic              noc_in_ready_o,

  output na_pkg::noc_flit_t noc_out_o,
  input  logic              noc_out_ready_i,

  output logic              irq_o
);

  import na_pkg::*;

  ahb_req_t  conf_req;
  ahb_rsp_t  conf_rsp;
  ahb_req_t  mp_req;
  ahb_rsp_t  mp_rsp;
  noc_flit_t mp_send;
  logic      mp_send_ready;
  noc_flit_t inbuf_flit;
  logic      inbuf_ready;

  ////////////////////
  // Bus side

  ahb_slave_decode u_decode (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .req_i     (ahb_req_i),
    .rsp_o     (ahb_rsp_o),
    .conf_req_o(conf_req),
    .conf_rsp_i(conf_rsp),
    .mp_req_o  (mp_req),
    .mp_rsp_i  (mp_rsp)
  );

  na_config_regs u_conf (
    .clk    (clk),
    .rst_n_i(rst_n_i),
    .req_i  (conf_req),
    .rsp_o  (conf_rsp)
  );

  mp_endpoint u_mp (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .req_i       (mp_req),
    .rsp_o       (mp_rsp),
    .send_o      (mp_send),
    .send_ready_i(mp_send_ready),
    .recv_i      (inbuf_flit),
    .recv_ready_o(inbuf_ready),
    .irq_o       (irq_o)
  );

  ////////////////////
  // NoC side

  noc_flit_buffer #(
    .DEPTH(BUF_DEPTH)
  ) u_inbuffer (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .in_i       (noc_in_i),
    .in_ready_o (noc_in_ready_o),
    .out_o      (inbuf_flit),
    .out_ready_i(inbuf_ready)
  );

  noc_flit_buffer #(
    .DEPTH(BUF_DEPTH)
  ) u_outbuffer (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .in_i       (mp_send),
    .in_ready_o (mp_send_ready),
    .out_o      (noc_out_o),
    .out_ready_i(noc_out_ready_i)
  );

endmodule

// File: source/mp_endpoint.sv
// Message endpoint, bus writes become outgoing flits and bus reads pop incoming flits
`timescale 1ns/100ps

module mp_endpoint (
  input  logic              clk,
  input  logic              rst_n_i,

  input  na_pkg::ahb_req_t  req_i,
  output na_pkg::ahb_rsp_t  rsp_o,

  output na_pkg::noc_flit_t send_o,
  input  logic              send_ready_i,

  input  na_pkg::noc_flit_t recv_i,
  output logic              recv_ready_o,

  output logic              irq_o
);

  import na_pkg::*;

  logic  accept;
  logic  dp_valid_q;
  logic  dp_write_q;
  offs_t dp_offs_q;
  logic  wr_flit;
  logic  rd_data;
  logic  rd_status;
  logic  hready;
  xlen_t rdata;

  assign accept = req_i.hsel &
                  ((req_i.htrans == HTRANS_NONSEQ) | (req_i.htrans == HTRANS_SEQ));

  ////////////////////
  // Address phase capture

  // Held while a write waits for the out buffer
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      dp_valid_q <= 1'b0;
    end else if (hready) begin
      dp_valid_q <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (hready && accept) begin
      dp_write_q <= req_i.hwrite;
      dp_offs_q  <= req_i.haddr[OFFS_WIDTH-1:0];
    end
  end

  ////////////////////
  // Data phase decode

  assign wr_flit   = dp_valid_q & dp_write_q &
                     ((dp_offs_q == MP_DATA_OFFS) | (dp_offs_q == MP_LAST_OFFS));
  assign rd_data   = dp_valid_q & ~dp_write_q & (dp_offs_q == MP_DATA_OFFS);
  assign rd_status = dp_valid_q & ~dp_write_q & (dp_offs_q == MP_STATUS_OFFS);

  // Outgoing flit, the last offset marks the end of a packet
  always_comb begin
    send_o.valid = wr_flit;
    send_o.last  = (dp_offs_q == MP_LAST_OFFS);
    send_o.data  = req_i.hwdata;
  end

  // Back-pressure from the out buffer stretches the write
  assign hready = wr_flit ? send_ready_i : 1'b1;

  // Pop happens only when a head flit is actually there
  assign recv_ready_o = rd_data & recv_i.valid;

  always_comb begin
    rdata = '0;
    if (rd_data && recv_i.valid) begin
      rdata = recv_i.data;
    end else if (rd_status) begin
      rdata[0] = recv_i.valid;
      rdata[1] = recv_i.valid & recv_i.last;
    end
  end

  assign rsp_o = '{hrdata: rdata, hready: hready, hresp: 1'b0};

  // Level interrupt while anything is waiting
  assign irq_o = recv_i.valid;

endmodule

// File: source/na_config_regs.sv
// Configuration region of the adapter, holds the identity registers and a scratch register
`timescale 1ns/100ps

module na_config_regs (
  input  logic             clk,
  input  logic             rst_n_i,

  input  na_pkg::ahb_req_t req_i,
  output na_pkg::ahb_rsp_t rsp_o
);

  import na_pkg::*;

  logic  accept;
  logic  dp_valid_q;
  logic  dp_write_q;
  offs_t dp_offs_q;
  xlen_t scratch_q;
  xlen_t rdata;

  assign accept = req_i.hsel &
                  ((req_i.htrans == HTRANS_NONSEQ) | (req_i.htrans == HTRANS_SEQ));

  ////////////////////
  // Address phase capture

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      dp_valid_q <= 1'b0;
    end else begin
      dp_valid_q <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      dp_write_q <= req_i.hwrite;
      dp_offs_q  <= req_i.haddr[OFFS_WIDTH-1:0];
    end
  end

  // Scratch write, hwdata arrives in the data phase
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      scratch_q <= '0;
    end else if (dp_valid_q && dp_write_q && (dp_offs_q == CONF_SCRATCH_OFFS)) begin
      scratch_q <= req_i.hwdata;
    end
  end

  always_comb begin
    rdata = '0;
    if (dp_valid_q && !dp_write_q) begin
      case (dp_offs_q)
        CONF_ID_OFFS:      rdata = xlen_t'(TILE_ID);
        CONF_VERSION_OFFS: rdata = xlen_t'(NA_VERSION);
        CONF_SCRATCH_OFFS: rdata = scratch_q;
        default:           rdata = '0;
      endcase
    end
  end

  // Zero wait states, never an error
  assign rsp_o = '{hrdata: rdata, hready: 1'b1, hresp: 1'b0};

endmodule

// File: source/ahb_slave_decode.sv
// AHB-Lite slave decoder, routes transfers to the config and message regions and errors the rest
`timescale 1ns/100ps

module ahb_slave_decode (
  input  logic             clk,
  input  logic             rst_n_i,

  input  na_pkg::ahb_req_t req_i,
  output na_pkg::ahb_rsp_t rsp_o,

  output na_pkg::ahb_req_t conf_req_o,
  input  na_pkg::ahb_rsp_t conf_rsp_i,

  output na_pkg::ahb_req_t mp_req_o,
  input  na_pkg::ahb_rsp_t mp_rsp_i
);

  import na_pkg::*;

  region_t       region;
  logic          hit_conf;
  logic          hit_mp;
  logic          xfer;
  ahb_rsp_t      rsp;
  logic          conf_owner_q;
  logic          mp_owner_q;
  decode_state_e state_q;
  decode_state_e state_d;

  assign region   = req_i.haddr[LADDR_WIDTH-1 -: REGION_WIDTH];
  assign hit_conf = (region == REGION_CONF);
  assign hit_mp   = (region == REGION_MP);

  // Address phase is taken only while the bus is ready
  assign xfer = req_i.hsel & rsp.hready &
                ((req_i.htrans == HTRANS_NONSEQ) | (req_i.htrans == HTRANS_SEQ));

  ////////////////////
  // Request fan-out

  always_comb begin
    conf_req_o      = req_i;
    conf_req_o.hsel = req_i.hsel & rsp.hready & hit_conf;
    mp_req_o        = req_i;
    mp_req_o.hsel   = req_i.hsel & rsp.hready & hit_mp;
  end

  ////////////////////
  // Data phase owner and error FSM

  always_comb begin
    state_d = state_q;
    case (state_q)
      DEC_ERR1: state_d = DEC_ERR2;
      // Idle and second error cycle both leave the bus ready
      default:  state_d = (xfer & ~hit_conf & ~hit_mp) ? DEC_ERR1 : DEC_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q      <= DEC_IDLE;
      conf_owner_q <= 1'b0;
      mp_owner_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      if (rsp.hready) begin
        conf_owner_q <= xfer & hit_conf;
        mp_owner_q   <= xfer & hit_mp;
      end
    end
  end

  // Response mux
  always_comb begin
    rsp = '{hrdata: '0, hready: 1'b1, hresp: 1'b0};
    case (state_q)
      DEC_ERR1: rsp = '{hrdata: '0, hready: 1'b0, hresp: 1'b1};
      DEC_ERR2: rsp = '{hrdata: '0, hready: 1'b1, hresp: 1'b1};
      default: begin
        if (conf_owner_q) begin
          rsp = conf_rsp_i;
        end else if (mp_owner_q) begin
          rsp = mp_rsp_i;
        end
      end
    endcase
  end

  assign rsp_o = rsp;

endmodule

// File: source/noc_flit_buffer.sv
// Flit FIFO with last markers, placed on each NoC direction of the adapter
`timescale 1ns/100ps

module noc_flit_buffer #(
  parameter int DEPTH = na_pkg::BUF_DEPTH
) (
  input  logic              clk,
  input  logic              rst_n_i,

  input  na_pkg::noc_flit_t in_i,
  output logic              in_ready_o,

  output na_pkg::noc_flit_t out_o,
  input  logic              out_ready_i
);

  import na_pkg::*;

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  flit_data_t       data_mem [DEPTH];
  logic             last_mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push;
  logic             pop;

  // Wraps at DEPTH, so any depth works
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    logic [PTR_W-1:0] nxt;
    if (ptr == PTR_W'(DEPTH - 1)) begin
      nxt = '0;
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  // Ready only looks at the fill level
  assign in_ready_o = (count_q < CNT_W'(DEPTH));
  assign push       = in_i.valid & in_ready_o;
  assign pop        = out_o.valid & out_ready_i;

  always_comb begin
    out_o.valid = (count_q != '0);
    out_o.last  = last_mem[rd_ptr_q];
    out_o.data  = data_mem[rd_ptr_q];
  end

  ////////////////////
  // Storage

  always_ff @(posedge clk) begin
    if (push) begin
      data_mem[wr_ptr_q] <= in_i.data;
      last_mem[wr_ptr_q] <= in_i.last;
    end
  end

  ////////////////////
  // Pointers and fill level

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

// File: source/na_pkg.sv
// Shared widths, address map, register offsets and bus/NoC types, imported by every adapter module
package na_pkg;

  ////////////////////
  // Widths

  localparam int XLEN         = 32;
  localparam int FLIT_WIDTH   = XLEN;
  localparam int LADDR_WIDTH  = 24;
  localparam int REGION_WIDTH = 4;
  localparam int OFFS_WIDTH   = LADDR_WIDTH - REGION_WIDTH;

  typedef logic [XLEN-1:0]         xlen_t;
  typedef logic [LADDR_WIDTH-1:0]  laddr_t;
  typedef logic [FLIT_WIDTH-1:0]   flit_data_t;
  typedef logic [REGION_WIDTH-1:0] region_t;
  typedef logic [OFFS_WIDTH-1:0]   offs_t;

  ////////////////////
  // Address map

  // Top nibble of the local address picks the region
  localparam region_t REGION_CONF = 4'h0;
  localparam region_t REGION_MP   = 4'h1;

  localparam int TILE_ID    = 5;
  localparam int NA_VERSION = 1;

  // Configuration region
  localparam offs_t CONF_ID_OFFS      = 'h0;
  localparam offs_t CONF_VERSION_OFFS = 'h4;
  localparam offs_t CONF_SCRATCH_OFFS = 'h8;

  // Message endpoint region
  localparam offs_t MP_DATA_OFFS   = 'h0;
  localparam offs_t MP_LAST_OFFS   = 'h4;
  localparam offs_t MP_STATUS_OFFS = 'h8;

  localparam int BUF_DEPTH = 4;

  ////////////////////
  // Bus and NoC types

  typedef enum logic [1:0] {
    HTRANS_IDLE   = 2'b00,
    HTRANS_BUSY   = 2'b01,
    HTRANS_NONSEQ = 2'b10,
    HTRANS_SEQ    = 2'b11
  } ahb_trans_e;

  // hwdata belongs to the data phase, all other fields to the address phase
  typedef struct packed {
    logic       hsel;
    laddr_t     haddr;
    logic       hwrite;
    logic [2:0] hsize;
    ahb_trans_e htrans;
    xlen_t      hwdata;
  } ahb_req_t;

  typedef struct packed {
    xlen_t hrdata;
    logic  hready;
    logic  hresp;
  } ahb_rsp_t;

  // Ready runs against the flow and is not part of the flit
  typedef struct packed {
    logic       valid;
    logic       last;
    flit_data_t data;
  } noc_flit_t;

  typedef enum logic [1:0] {
    DEC_IDLE,
    DEC_ERR1,
    DEC_ERR2
  } decode_state_e;

endpackage
